/* verilog/dot_pkg.sv */
`default_nettype none

package dot_pkg;

   // lane count, has to stay a power of two for the adder tree
   localparam int n_lanes = 8;

   // pairwise adder levels between the products and the final sum
   localparam int tree_levels = $clog2(n_lanes);

   // sample and coefficient width
   localparam int sample_w = 16;

   // full product width, also used for every partial sum
   localparam int prod_w = 32;

   // lane index width
   localparam int lane_addr_w = $clog2(n_lanes);

   typedef logic signed [sample_w-1:0] sample_t;
   typedef logic signed [sample_w-1:0] coef_t;
   typedef logic signed [prod_w-1:0]   prod_t;
   typedef logic [lane_addr_w-1:0]     lane_addr_t;

   // single coefficient write, 20 bits
   typedef struct packed {
      logic       en;
      lane_addr_t addr;
      coef_t      value;
   } coef_wr_t;

   // whole coefficient set, lane 0 in the low bits
   typedef coef_t [n_lanes-1:0] coef_vec_t;

   // sample vector with its valid strobe, 129 bits
   typedef struct packed {
      logic                  valid;
      sample_t [n_lanes-1:0] samples;
   } sample_bus_t;

   // registered multiplier outputs, 257 bits
   typedef struct packed {
      logic                valid;
      prod_t [n_lanes-1:0] prods;
   } product_bus_t;

endpackage

`default_nettype wire

/* verilog/coef_bank.sv */
`timescale 1ns/1ps
`default_nettype none

// one coefficient register per lane, all of them visible to the
// multipliers at the same time
module coef_bank (
   input  logic               clk,
   input  logic               rst,
   input  dot_pkg::coef_wr_t  coef_wr,
   output dot_pkg::coef_vec_t coefs
);

   // one-hot lane select for the current write
   logic [dot_pkg::n_lanes-1:0] wr_sel;

   // per-lane storage
   dot_pkg::coef_t coef_q [dot_pkg::n_lanes];

   // address decode, nothing selected without the enable
   always_comb begin
      wr_sel = '0;
      if (coef_wr.en) begin
         wr_sel[coef_wr.addr] = 1'b1;
      end
   end

   genvar i;
   generate
      for (i = 0; i < dot_pkg::n_lanes; i++) begin : g_coef
         // cleared on reset so an unloaded lane contributes nothing
         always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
               coef_q[i] <= '0;
            end else if (wr_sel[i]) begin
               coef_q[i] <= coef_wr.value;
            end
         end
      end
   endgenerate

   // new value shows up after the write edge, so a sample taken
   // on that same edge still multiplies with the old coefficient
   always_comb begin
      for (int k = 0; k < dot_pkg::n_lanes; k++) begin
         coefs[k] = coef_q[k];
      end
   end

endmodule

`default_nettype wire

/* verilog/dsp_lane_array.sv */
`timescale 1ns/1ps
`default_nettype none

// row of signed 16x16 multipliers, each with its product register,
// the way a DSP slice column is usually used
module dsp_lane_array (
   input  logic                  clk,
   input  logic                  rst,
   input  dot_pkg::sample_bus_t  sample_in,
   input  dot_pkg::coef_vec_t    coefs,
   output dot_pkg::product_bus_t products
);

   // registered products, one per lane
   dot_pkg::prod_t prod_q [dot_pkg::n_lanes];

   // valid travels with the products
   logic valid_q;

   genvar i;
   generate
      for (i = 0; i < dot_pkg::n_lanes; i++) begin : g_lane
         // lane operands, both signed
         dot_pkg::sample_t lane_sample;
         dot_pkg::coef_t   lane_coef;
         dot_pkg::prod_t   lane_prod;

         assign lane_sample = sample_in.samples[i];
         assign lane_coef   = coefs[i];

         // full 32-bit signed product, cannot overflow
         assign lane_prod = lane_sample * lane_coef;

         // payload only, loads on a valid vector and holds otherwise
         always_ff @(posedge clk) begin
            if (sample_in.valid) begin
               prod_q[i] <= lane_prod;
            end
         end
      end
   endgenerate

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= sample_in.valid;
      end
   end

   // pack the lanes back onto the product bus
   always_comb begin
      products.valid = valid_q;
      for (int k = 0; k < dot_pkg::n_lanes; k++) begin
         products.prods[k] = prod_q[k];
      end
   end

endmodule

`default_nettype wire

/* verilog/adder_tree.sv */
`timescale 1ns/1ps
`default_nettype none

// sums all lane products through a combinational tree of pairwise
// adders, only the final sum is registered
//
// every partial sum stays at 32 bits, so an overflowing total wraps
module adder_tree (
   input  logic                  clk,
   input  logic                  rst,
   input  dot_pkg::product_bus_t products,
   output dot_pkg::prod_t        result,
   output logic                  result_valid
);

   // number of entries in the partial sum array: the inputs, then
   // each level's outputs, ending with the single total
   localparam int n_sums = 2 * dot_pkg::n_lanes - 1;

   // index of the total, the last entry
   localparam int top_idx = n_sums - 1;

   // flat storage for all partial sums, level by level
   dot_pkg::prod_t part_sum [n_sums];

   genvar l;
   genvar a;

   generate
      // level 0 inputs come straight from the product bus
      for (a = 0; a < dot_pkg::n_lanes; a++) begin : g_in
         assign part_sum[a] = products.prods[a];
      end

      for (l = 0; l < dot_pkg::tree_levels; l++) begin : g_level
         // adders on this level
         localparam int n_add = dot_pkg::n_lanes >> (l + 1);

         // first entry read by this level
         localparam int in_base = 2 * dot_pkg::n_lanes - 2 * (dot_pkg::n_lanes >> l);

         // first entry written by this level
         localparam int out_base = in_base + 2 * n_add;

         for (a = 0; a < n_add; a++) begin : g_add
            assign part_sum[out_base + a] =
               part_sum[in_base + 2 * a] + part_sum[in_base + 2 * a + 1];
         end
      end
   endgenerate

   // output register, loads the total only for a valid product set
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         result <= '0;
      end else if (products.valid) begin
         result <= part_sum[top_idx];
      end
   end

   // one cycle behind the product valid
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         result_valid <= 1'b0;
      end else begin
         result_valid <= products.valid;
      end
   end

endmodule

`default_nettype wire

/* verilog/dot_product_top.sv */
`timescale 1ns/1ps
`default_nettype none

// eight-lane dot product: coefficient bank, multiplier row and adder
// tree, two cycles from sample valid to result valid
module dot_product_top (
   input  logic                 clk,
   input  logic                 rst,
   input  dot_pkg::coef_wr_t    coef_wr,
   input  dot_pkg::sample_bus_t sample_in,
   output dot_pkg::prod_t       result,
   output logic                 result_valid
);

   // stored coefficients, all lanes in parallel
   dot_pkg::coef_vec_t coefs;

   // registered multiplier outputs
   dot_pkg::product_bus_t products;

   coef_bank u_coef_bank (
      .clk     (clk),
      .rst     (rst),
      .coef_wr (coef_wr),
      .coefs   (coefs)
   );

   // first cycle of latency
   dsp_lane_array u_dsp_lane_array (
      .clk       (clk),
      .rst       (rst),
      .sample_in (sample_in),
      .coefs     (coefs),
      .products  (products)
   );

   // second cycle of latency
   adder_tree u_adder_tree (
      .clk          (clk),
      .rst          (rst),
      .products     (products),
      .result       (result),
      .result_valid (result_valid)
   );

endmodule

`default_nettype wire

/* bench/dot_product_sva.sv */
`timescale 1ns/1ps
`default_nettype none

// port-level checks on the dot product top
module dot_product_sva (
   input logic           clk,
   input logic           rst,
   input logic           sample_valid,
   input dot_pkg::prod_t result,
   input logic           result_valid
);

   // count of failed assertions
   int unsigned fail_count = 0;

   // outputs held at their reset values
   a_reset_quiet: assert property (@(posedge clk) rst |-> (!result_valid && result == '0))
      else begin
         $error("result_valid or result not cleared while reset is held");
         fail_count++;
      end

   // an accepted vector always shows up two cycles later
   a_latency: assert property (@(posedge clk) disable iff (rst)
                               $past(sample_valid, 2) |-> result_valid)
      else begin
         $error("no result_valid two cycles after an accepted vector");
         fail_count++;
      end

   a_no_spurious: assert property (@(posedge clk) disable iff (rst)
                                   result_valid |-> $past(sample_valid, 2))
      else begin
         $error("result_valid high without a vector two cycles earlier");
         fail_count++;
      end

endmodule

bind dot_product_top dot_product_sva u_sva (
   .clk          (clk),
   .rst          (rst),
   .sample_valid (sample_in.valid),
   .result       (result),
   .result_valid (result_valid)
);

`default_nettype wire

/* bench/dot_product_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dot_product_tb;

   localparam int reset_cycles = 4;
   localparam int latency = 2;
   localparam int max_rows = 64;

   typedef dot_pkg::sample_t [dot_pkg::n_lanes-1:0] sample_vec_t;

   // one table row holds an optional coefficient write and a sample vector
   typedef struct packed {
      logic                wr_en;
      dot_pkg::lane_addr_t wr_lane;
      dot_pkg::coef_t      wr_value;
      logic                s_valid;
      sample_vec_t         samples;
   } row_t;

   logic                 clk;
   logic                 rst;
   dot_pkg::coef_wr_t    coef_wr;
   dot_pkg::sample_bus_t sample_in;
   dot_pkg::prod_t       result;
   logic                 result_valid;

   row_t  rows [max_rows];
   string row_name [max_rows];
   int    n_rows;

   // reference copy of the coefficient bank
   dot_pkg::coef_t coef_model [dot_pkg::n_lanes];

   // pending results and the cycle each one is due
   dot_pkg::prod_t exp_q [$];
   int             due_q [$];
   string          name_q [$];

   int          cycles;
   int          cycle_limit;
   int          value_errors;
   int          timing_errors;
   logic        seen_result;

   dot_product_top UUT (
      .clk          (clk),
      .rst          (rst),
      .coef_wr      (coef_wr),
      .sample_in    (sample_in),
      .result       (result),
      .result_valid (result_valid)
   );

   always #10 clk = ~clk;

   // lane 0 is the first argument
   function automatic sample_vec_t vec8(input int s0, input int s1, input int s2, input int s3,
                                        input int s4, input int s5, input int s6, input int s7);
      sample_vec_t v;
      v[0] = dot_pkg::sample_t'(s0);
      v[1] = dot_pkg::sample_t'(s1);
      v[2] = dot_pkg::sample_t'(s2);
      v[3] = dot_pkg::sample_t'(s3);
      v[4] = dot_pkg::sample_t'(s4);
      v[5] = dot_pkg::sample_t'(s5);
      v[6] = dot_pkg::sample_t'(s6);
      v[7] = dot_pkg::sample_t'(s7);
      return v;
   endfunction

   function automatic sample_vec_t rand_vec();
      sample_vec_t v;
      for (int k = 0; k < dot_pkg::n_lanes; k++) begin
         v[k] = dot_pkg::sample_t'($urandom());
      end
      return v;
   endfunction

   // sum of the signed products truncated to the low 32 bits
   function automatic dot_pkg::prod_t dot_expected(input sample_vec_t s);
      longint           acc;
      dot_pkg::sample_t s_k;
      dot_pkg::coef_t   c_k;
      acc = 0;
      for (int k = 0; k < dot_pkg::n_lanes; k++) begin
         s_k = s[k];
         c_k = coef_model[k];
         acc += longint'(s_k) * longint'(c_k);
      end
      return dot_pkg::prod_t'(acc);
   endfunction

   task automatic add_row(input string name, input logic wr_en, input int lane, input int value,
                          input logic s_valid, input sample_vec_t samples);
      rows[n_rows].wr_en    = wr_en;
      rows[n_rows].wr_lane  = dot_pkg::lane_addr_t'(lane);
      rows[n_rows].wr_value = dot_pkg::coef_t'(value);
      rows[n_rows].s_valid  = s_valid;
      rows[n_rows].samples  = samples;
      row_name[n_rows]      = name;
      n_rows++;
   endtask

   task automatic build_table();
      int k;
      int load_val [8] = '{3, -2, 5, 7, -1, 4, -6, 2};
      n_rows = 0;
      for (k = 0; k < 3; k++) begin
         add_row("after_reset", 1'b0, 0, 0, 1'b0, '0);
      end
      for (k = 0; k < 8; k++) begin
         add_row("coef_load", 1'b1, k, load_val[k], 1'b0, '0);
      end
      add_row("basic", 1'b0, 0, 0, 1'b1, vec8(1, 2, 3, 4, 5, 6, 7, 8));
      add_row("signed", 1'b0, 0, 0, 1'b1, vec8(-100, 200, -300, 400, -500, 600, -700, 800));
      // 2*3 + 3*(-2) cancels out
      add_row("cancel", 1'b0, 0, 0, 1'b1, vec8(2, 3, 0, 0, 0, 0, 0, 0));
      add_row("gap", 1'b0, 0, 0, 1'b0, '0);
      for (k = 0; k < 8; k++) begin
         add_row("wrap_load", 1'b1, k, -32768, 1'b0, '0);
      end
      // seven times 2**30 lands in the negative range
      add_row("wrap_neg", 1'b0, 0, 0, 1'b1,
              vec8(-32768, -32768, -32768, -32768, -32768, -32768, -32768, 0));
      add_row("wrap_pos", 1'b0, 0, 0, 1'b1,
              vec8(32767, 32767, 32767, 32767, 32767, 32767, 32767, 32767));
      add_row("wrap_zero", 1'b0, 0, 0, 1'b1,
              vec8(-32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768));
      // lane 0 write on the same edge as a sample
      add_row("same_edge_old", 1'b1, 0, 5, 1'b1, vec8(1, 1, 1, 1, 1, 1, 1, 1));
      add_row("same_edge_new", 1'b0, 0, 0, 1'b1, vec8(1, 1, 1, 1, 1, 1, 1, 1));
      for (k = 0; k < 12; k++) begin
         add_row("random", (k % 3 == 0), k % 8, $urandom(), (k % 4 != 3), rand_vec());
      end
   endtask

   task automatic apply_row(input int r);
      if (rows[r].s_valid) begin
         exp_q.push_back(dot_expected(rows[r].samples));
         due_q.push_back(cycles + latency);
         name_q.push_back(row_name[r]);
      end
      // model takes the write only after this sample's expected value
      if (rows[r].wr_en) begin
         coef_model[rows[r].wr_lane] = rows[r].wr_value;
      end
      coef_wr.en        = rows[r].wr_en;
      coef_wr.addr      = rows[r].wr_lane;
      coef_wr.value     = rows[r].wr_value;
      sample_in.valid   = rows[r].s_valid;
      sample_in.samples = rows[r].samples;
   endtask

   task automatic report_counts();
      $display("value errors: %0d, timing errors: %0d, assertion failures: %0d",
               value_errors, timing_errors, UUT.u_sva.fail_count);
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         report_counts();
         $display("** FAIL **");
         $finish;
      end
   end

   // outputs are stable at the falling edge
   always @(negedge clk) begin
      if (!rst) begin
         if (result_valid) begin
            seen_result <= 1'b1;
            assert (exp_q.size() != 0) else begin
               $display("result_valid went high at cycle %0d with no vector pending", cycles);
               timing_errors++;
            end
            if (exp_q.size() != 0) begin
               assert (due_q[0] == cycles) else begin
                  $display("%s result arrived at cycle %0d, due at cycle %0d",
                           name_q[0], cycles, due_q[0]);
                  timing_errors++;
               end
               assert (result == exp_q[0]) else begin
                  $display("error: %s expected %0d actual %0d", name_q[0], exp_q[0], result);
                  value_errors++;
               end
               void'(exp_q.pop_front());
               void'(due_q.pop_front());
               void'(name_q.pop_front());
            end
         end else begin
            assert (exp_q.size() == 0 || due_q[0] != cycles) else begin
               $display("%s result missing at cycle %0d", name_q[0], cycles);
               timing_errors++;
            end
            if (!seen_result) begin
               assert (result == '0) else begin
                  $display("error: after_reset expected 0 actual %0d", result);
                  value_errors++;
               end
            end
         end
      end
   end

   initial begin
      void'($urandom(32'h80a1));
      clk           = 1'b0;
      rst           = 1'b1;
      coef_wr       = '0;
      sample_in     = '0;
      cycles        = 0;
      value_errors  = 0;
      timing_errors = 0;
      seen_result   = 1'b0;
      for (int k = 0; k < dot_pkg::n_lanes; k++) begin
         coef_model[k] = '0;
      end
      build_table();
      cycle_limit = n_rows + reset_cycles + latency + 20;

      repeat (reset_cycles) @(posedge clk);
      #1 rst = 1'b0;

      for (int r = 0; r < n_rows; r++) begin
         @(posedge clk);
         #1 apply_row(r);
      end
      @(posedge clk);
      #1;
      coef_wr   = '0;
      sample_in = '0;

      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      // a few idle cycles to catch a stray result_valid
      repeat (latency + 1) @(posedge clk);

      report_counts();
      if (value_errors == 0 && timing_errors == 0 && UUT.u_sva.fail_count == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
verilog/dot_pkg.sv
verilog/coef_bank.sv
verilog/dsp_lane_array.sv
verilog/adder_tree.sv
verilog/dot_product_top.sv
bench/dot_product_sva.sv
bench/dot_product_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the dot product testbench with Verilator.
# Exits non-zero when the build fails, the simulation fails, or the
# log reports a failing run.

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=dot_product_sim

verilator --binary --timing --assert -Wno-fatal \
   -f compile.f \
   --top-module dot_product_tb \
   -Mdir "$OBJ" -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
   echo "run.sh: verilator build failed with status $status"
   exit 1
fi

"./$OBJ/$BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "run.sh: simulation exited with status $status"
   exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
   echo "run.sh: testbench reported failure"
   exit 1
fi

if ! grep -q '\*\* PASS \*\*' "$LOG"; then
   echo "run.sh: simulation ended without a result line"
   exit 1
fi

echo "run.sh: simulation passed"
exit 0
